// File: rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 variants
    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    localparam int MUL_STEPS = 32;
    localparam int NUM_REGS  = 32;

endpackage

// File: rv_pipe_if.sv
`timescale 1ns/10ps

interface rv_id_ex_if;
    import rv_pkg::*;

    logic     valid;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     rd_we;
    alu_op_t  alu_op;
    logic     is_mul;
    logic     use_rs1;
    logic     use_rs2;
    xlen_t    op_a;
    xlen_t    op_b;

    modport src (output valid, rs1, rs2, rd, rd_we, alu_op, is_mul,
                 use_rs1, use_rs2, op_a, op_b);
    modport dst (input valid, rs1, rs2, rd, rd_we, alu_op, is_mul,
                 use_rs1, use_rs2, op_a, op_b);
endinterface

interface rv_wb_if;
    import rv_pkg::*;

    logic     valid;
    reg_idx_t rd;
    xlen_t    data;

    modport src (output valid, rd, data);
    modport dst (input valid, rd, data);
    // Observation only, for the report ports
    modport mon (input valid, rd, data);
endinterface

// File: rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::xlen_t    data1,
    output rv_pkg::xlen_t    data2,
    rv_wb_if.dst             wb
);
    import rv_pkg::*;

    xlen_t regs [NUM_REGS];

    // Write-through so a same-cycle read sees the new value
    assign data1 = (rs1 == '0) ? '0 :
                   (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
    assign data2 = (rs2 == '0) ? '0 :
                   (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

// File: rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::xlen_t   a,
    input  rv_pkg::xlen_t   b,
    output rv_pkg::xlen_t   result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// File: rv_mul_unit.sv
`timescale 1ns/10ps

module rv_mul_unit (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  rv_pkg::xlen_t a,
    input  rv_pkg::xlen_t b,
    output rv_pkg::xlen_t product,
    output logic          done
);
    import rv_pkg::*;

    logic                               active;
    logic [$clog2(MUL_STEPS + 1) - 1:0] steps;
    xlen_t                              acc;
    xlen_t                              mcand;
    xlen_t                              mplier;
    xlen_t                              acc_in;
    xlen_t                              mcand_in;
    xlen_t                              mplier_in;

    // First step happens on the start edge
    assign acc_in    = start ? '0 : acc;
    assign mcand_in  = start ? a : mcand;
    assign mplier_in = start ? b : mplier;

    assign done    = active && (steps == MUL_STEPS);
    assign product = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            steps  <= '0;
        end else if (start) begin
            active <= 1'b1;
            steps  <= 1'b1;
        end else if (done) begin
            active <= 1'b0;
        end else if (active) begin
            steps <= steps + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start || (active && !done)) begin
            acc    <= mplier_in[0] ? acc_in + mcand_in : acc_in;
            mcand  <= mcand_in << 1;
            mplier <= mplier_in >> 1;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        start |-> !active);

endmodule

// File: rv_decode_stage.sv
`timescale 1ns/10ps

module rv_decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  rv_pkg::xlen_t    instr,
    input  logic             busy,
    output rv_pkg::reg_idx_t rf_rs1,
    output rv_pkg::reg_idx_t rf_rs2,
    input  rv_pkg::xlen_t    rf_data1,
    input  rv_pkg::xlen_t    rf_data2,
    rv_id_ex_if.src          id_ex
);
    import rv_pkg::*;

    xlen_t      ir;
    logic       ir_valid;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm;
    logic       legal;

    function automatic alu_op_t base_op(input logic [2:0] f3);
        case (f3)
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    assign instr_ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            ir_valid <= 1'b0;
        end else if (!busy) begin
            ir_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            ir <= instr;
        end
    end

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];
    assign rf_rs1 = ir[19:15];
    assign rf_rs2 = ir[24:20];

    always_comb begin
        id_ex.alu_op  = ALU_ADD;
        id_ex.is_mul  = 1'b0;
        id_ex.use_rs1 = 1'b0;
        id_ex.use_rs2 = 1'b0;
        legal         = 1'b0;
        imm           = '0;
        case (opcode)
            OPC_LUI: begin
                legal        = 1'b1;
                id_ex.alu_op = ALU_PASS_B;
                imm          = {ir[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                id_ex.use_rs1 = 1'b1;
                imm           = {{20{ir[31]}}, ir[31:20]};
                id_ex.alu_op  = base_op(funct3);
                if (funct3 == F3_SLL) begin
                    legal = (funct7 == FUNCT7_BASE);
                end else if (funct3 == F3_SRL_SRA) begin
                    legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                    if (funct7 == FUNCT7_ALT) begin
                        id_ex.alu_op = ALU_SRA;
                    end
                end else begin
                    legal = 1'b1;
                end
            end
            OPC_OP: begin
                id_ex.use_rs1 = 1'b1;
                id_ex.use_rs2 = 1'b1;
                if (funct7 == FUNCT7_BASE) begin
                    legal        = 1'b1;
                    id_ex.alu_op = base_op(funct3);
                end else if (funct7 == FUNCT7_ALT) begin
                    legal        = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
                    id_ex.alu_op = (funct3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
                end else if (funct7 == FUNCT7_MULDIV) begin
                    // Only the low-word multiply is implemented
                    legal        = (funct3 == F3_ADD_SUB);
                    id_ex.is_mul = legal;
                end
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign id_ex.valid = ir_valid;
    assign id_ex.rs1   = rf_rs1;
    assign id_ex.rs2   = rf_rs2;
    assign id_ex.rd    = ir[11:7];
    assign id_ex.rd_we = legal && (ir[11:7] != '0);
    assign id_ex.op_a  = id_ex.use_rs1 ? rf_data1 : '0;
    assign id_ex.op_b  = id_ex.use_rs2 ? rf_data2 : imm;

    // Refused instruction must be held by the source
    a_instr_stable: assert property (@(posedge clk) disable iff (rst)
        instr_valid && !instr_ready |=> $stable(instr));

endmodule

// File: rv_exec_stage.sv
`timescale 1ns/10ps

module rv_exec_stage (
    input  logic    clk,
    input  logic    rst,
    rv_id_ex_if.dst id_ex,
    output logic    busy,
    rv_wb_if.src    wb
);
    import rv_pkg::*;

    logic     ex_valid;
    reg_idx_t ex_rd;
    logic     ex_rd_we;
    alu_op_t  ex_alu_op;
    logic     ex_is_mul;
    xlen_t    ex_a;
    xlen_t    ex_b;
    xlen_t    ex_result;
    xlen_t    alu_result;
    xlen_t    mul_product;
    logic     mul_start;
    logic     mul_done;
    logic     ex_fwd_a;
    logic     ex_fwd_b;
    logic     res_fwd_a;
    logic     res_fwd_b;
    xlen_t    fwd_a;
    xlen_t    fwd_b;
    logic     res_valid;
    reg_idx_t res_rd;
    xlen_t    res_data;

    rv_alu alu_i (
        .op     (ex_alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (alu_result)
    );

    rv_mul_unit mul_i (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .a       (ex_a),
        .b       (ex_b),
        .product (mul_product),
        .done    (mul_done)
    );

    assign ex_result = ex_is_mul ? mul_product : alu_result;
    assign busy      = ex_valid && ex_is_mul && !mul_done;

    // Newest producer wins, x0 never forwarded
    assign ex_fwd_a  = id_ex.use_rs1 && id_ex.rs1 != '0 && ex_valid && ex_rd_we
                       && ex_rd == id_ex.rs1;
    assign ex_fwd_b  = id_ex.use_rs2 && id_ex.rs2 != '0 && ex_valid && ex_rd_we
                       && ex_rd == id_ex.rs2;
    assign res_fwd_a = id_ex.use_rs1 && id_ex.rs1 != '0 && res_valid && res_rd == id_ex.rs1;
    assign res_fwd_b = id_ex.use_rs2 && id_ex.rs2 != '0 && res_valid && res_rd == id_ex.rs2;

    assign fwd_a = ex_fwd_a ? ex_result : res_fwd_a ? res_data : id_ex.op_a;
    assign fwd_b = ex_fwd_b ? ex_result : res_fwd_b ? res_data : id_ex.op_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid  <= 1'b0;
            mul_start <= 1'b0;
            res_valid <= 1'b0;
            wb.valid  <= 1'b0;
        end else begin
            if (!busy) begin
                ex_valid <= id_ex.valid;
            end
            mul_start <= !busy && id_ex.valid && id_ex.is_mul;
            res_valid <= ex_valid && ex_rd_we && !busy;
            wb.valid  <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            ex_rd     <= id_ex.rd;
            ex_rd_we  <= id_ex.rd_we;
            ex_alu_op <= id_ex.alu_op;
            ex_is_mul <= id_ex.is_mul;
            ex_a      <= fwd_a;
            ex_b      <= fwd_b;
        end
        res_rd   <= ex_rd;
        res_data <= ex_result;
        wb.rd    <= res_rd;
        wb.data  <= res_data;
    end

    a_no_x0_report: assert property (@(posedge clk) disable iff (rst)
        wb.valid |-> wb.rd != '0);

endmodule

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  rv_pkg::xlen_t    instr,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::xlen_t    wb_data
);
    import rv_pkg::*;

    logic     busy;
    reg_idx_t rf_rs1;
    reg_idx_t rf_rs2;
    xlen_t    rf_data1;
    xlen_t    rf_data2;

    rv_id_ex_if id_ex_if ();
    rv_wb_if    wb_if ();

    rv_decode_stage decode_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .busy        (busy),
        .rf_rs1      (rf_rs1),
        .rf_rs2      (rf_rs2),
        .rf_data1    (rf_data1),
        .rf_data2    (rf_data2),
        .id_ex       (id_ex_if.src)
    );

    rv_regfile regfile_i (
        .clk   (clk),
        .rst   (rst),
        .rs1   (rf_rs1),
        .rs2   (rf_rs2),
        .data1 (rf_data1),
        .data2 (rf_data2),
        .wb    (wb_if.dst)
    );

    rv_exec_stage exec_i (
        .clk   (clk),
        .rst   (rst),
        .id_ex (id_ex_if.dst),
        .busy  (busy),
        .wb    (wb_if.src)
    );

    // Report port mirrors the register file write
    assign wb_valid = wb_if.valid;
    assign wb_rd    = wb_if.rd;
    assign wb_data  = wb_if.data;

endmodule

// File: rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Instruction encoders
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
endfunction

// RV32I/M rules applied to the shadow registers
function automatic bit model_instr(input logic [31:0] ins, output logic [4:0] rd,
                                   output logic [31:0] val);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    bit          ok;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    rd  = ins[11:7];
    a   = shadow[ins[19:15]];
    ok  = 1'b1;
    val = '0;
    if (opc == OPC_LUI) begin
        val = {ins[31:12], 12'b0};
        return rd != 0;
    end
    if (opc == OPC_OP_IMM) begin
        b = {{20{ins[31]}}, ins[31:20]};
        ok = (f3 == 3'd1) ? (f7 == 7'h00) :
             (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
    end else if (opc == OPC_OP) begin
        b  = shadow[ins[24:20]];
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) ||
             (f7 == 7'h01 && f3 == 3'd0);
    end else begin
        return 1'b0;
    end
    sh = b[4:0];
    case (f3)
        3'd0: val = (opc == OPC_OP && f7 == 7'h20) ? a - b : a + b;
        3'd1: val = a << sh;
        3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: val = (a < b) ? 32'd1 : 32'd0;
        3'd4: val = a ^ b;
        3'd5: begin
            if (f7 == 7'h20) begin
                val = $signed(a) >>> sh;
            end else begin
                val = a >> sh;
            end
        end
        3'd6: val = a | b;
        default: val = a & b;
    endcase
    // Low word of the product
    if (opc == OPC_OP && f7 == 7'h01) begin
        val = a * b;
    end
    return ok && rd != 0;
endfunction

`endif

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int NUM_INSTRS = 53;
    localparam int NUM_MULS   = 2;
    localparam int WATCHDOG_CYCLES = 8 + 200 * NUM_INSTRS + 40 * NUM_MULS;
    localparam int DRAIN_CYCLES = 4 * MUL_STEPS;

    logic             clk;
    logic             rst;
    logic             instr_valid;
    logic             instr_ready;
    xlen_t            instr;
    logic             wb_valid;
    reg_idx_t         wb_rd;
    xlen_t            wb_data;

    logic [31:0] shadow [32];
    logic [36:0] exp_q [$];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          last_waits;

    `include "rv_ref_model.svh"

    rv_core dut_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    // Reports are compared in program order
    always @(negedge clk) begin
        logic [36:0] e;
        if (!rst && wb_valid) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("Unexpected writeback report for x%0d at %0t", wb_rd, $time);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                assert (wb_rd == e[36:32] && wb_data == e[31:0]) else begin
                    errors++;
                    $display("Error at %0t: report x%0d = %08h, expected x%0d = %08h",
                             $time, wb_rd, wb_data, e[36:32], e[31:0]);
                end
            end
        end
    end

    task automatic issue(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [31:0] val;
        if (model_instr(ins, rd, val)) begin
            shadow[rd] = val;
            exp_q.push_back({rd, val});
        end
        last_waits  = 0;
        instr_valid = 1'b1;
        instr       = ins;
        @(negedge clk);
        while (!instr_ready) begin
            last_waits++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic drain_reports();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        // Wait out the pipeline depth for stray reports
        repeat (4) @(negedge clk);
        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected reports never arrived", exp_q.size());
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic load_random(input logic [4:0] rd);
        issue(lui_word(20'(rand_bits(20)), rd));
        issue(i_type(12'(rand_bits(12)), rd, 3'd0, rd));
    endtask

    task automatic reset_and_lui();
        checks++;
        assert (!wb_valid && instr_ready) else begin
            errors++;
            $display("Error at %0t: after reset wb_valid=%b instr_ready=%b",
                     $time, wb_valid, instr_ready);
        end
        issue(lui_word(20'h12345, 5'd1));
        issue(i_type(12'hffb, 5'd0, 3'd0, 5'd2));
        issue(i_type(12'h678, 5'd1, 3'd0, 5'd3));
        drain_reports();
    endtask

    task automatic alu_op_sweep();
        logic [11:0] imm;
        load_random(5'd5);
        load_random(5'd6);
        for (int i = 0; i < 8; i++) begin
            issue(r_type(FUNCT7_BASE, 5'd6, 5'd5, 3'(i), 5'(7 + i)));
        end
        issue(r_type(FUNCT7_ALT, 5'd6, 5'd5, 3'd0, 5'd15));
        issue(r_type(FUNCT7_ALT, 5'd6, 5'd5, 3'd5, 5'd16));
        for (int i = 0; i < 8; i++) begin
            if (i == 1 || i == 5) begin
                imm = {7'h00, 5'(rand_bits(5))};
            end else begin
                imm = 12'(rand_bits(12));
            end
            issue(i_type(imm, 5'd5, 3'(i), 5'(17 + i)));
        end
        issue(i_type({FUNCT7_ALT, 5'(rand_bits(5))}, 5'd6, 3'd5, 5'd25));
        drain_reports();
    endtask

    task automatic forwarding_chain();
        issue(i_type(12'(rand_bits(12)), 5'd0, 3'd0, 5'd1));
        issue(r_type(FUNCT7_BASE, 5'd1, 5'd1, 3'd0, 5'd2));
        issue(r_type(FUNCT7_BASE, 5'd2, 5'd1, 3'd0, 5'd3));
        issue(i_type(12'd1, 5'd1, 3'd0, 5'd4));
        issue(i_type(12'd2, 5'd1, 3'd0, 5'd5));
        // Write to x0 and read it back
        issue(i_type(12'd5, 5'd1, 3'd0, 5'd0));
        issue(r_type(FUNCT7_BASE, 5'd1, 5'd0, 3'd0, 5'd6));
        issue(r_type(FUNCT7_ALT, 5'd0, 5'd6, 3'd0, 5'd7));
        issue(r_type(FUNCT7_BASE, 5'd4, 5'd3, 3'd4, 5'd8));
        drain_reports();
    endtask

    task automatic multiply_stall();
        load_random(5'd10);
        load_random(5'd11);
        issue(r_type(FUNCT7_MULDIV, 5'd11, 5'd10, 3'd0, 5'd12));
        issue(r_type(FUNCT7_BASE, 5'd10, 5'd12, 3'd0, 5'd13));
        issue(r_type(FUNCT7_BASE, 5'd13, 5'd12, 3'd4, 5'd14));
        checks++;
        assert (last_waits >= MUL_STEPS - 1 && last_waits <= MUL_STEPS + 2) else begin
            errors++;
            $display("Error at %0t: instr_ready low for %0d cycles behind a MUL, expected %0d to %0d",
                     $time, last_waits, MUL_STEPS - 1, MUL_STEPS + 2);
        end
        issue(r_type(FUNCT7_MULDIV, 5'd12, 5'd12, 3'd0, 5'd15));
        issue(r_type(FUNCT7_ALT, 5'd11, 5'd15, 3'd0, 5'd16));
        drain_reports();
    endtask

    task automatic nop_and_order();
        issue(i_type(12'(rand_bits(12)), 5'd0, 3'd0, 5'd20));
        issue({12'h000, 5'd20, 3'b010, 5'd21, 7'b0000011});
        issue(r_type(FUNCT7_BASE, 5'd20, 5'd20, 3'd0, 5'd22));
        issue(r_type(FUNCT7_MULDIV, 5'd22, 5'd20, 3'd4, 5'd23));
        issue(i_type({FUNCT7_ALT, 5'd3}, 5'd22, 3'd1, 5'd24));
        issue({20'h00010, 5'd25, 7'b1101111});
        issue(i_type(12'(rand_bits(12)), 5'd22, 3'd6, 5'd26));
        issue(r_type(FUNCT7_MULDIV, 5'd26, 5'd22, 3'd1, 5'd27));
        issue(r_type(FUNCT7_ALT, 5'd20, 5'd26, 3'd0, 5'd28));
        drain_reports();
    endtask

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'hc2bd_8c44;
        errors      = 0;
        checks      = 0;
        last_waits  = 0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_and_lui();
        alu_op_sweep();
        forwarding_chain();
        multiply_stall();
        nop_and_order();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
rv_pkg.sv
rv_pipe_if.sv
rv_regfile.sv
rv_alu.sv
rv_mul_unit.sv
rv_decode_stage.sv
rv_exec_stage.sv
rv_core.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_pipe_if.sv
  - rv_regfile.sv
  - rv_alu.sv
  - rv_mul_unit.sv
  - rv_decode_stage.sv
  - rv_exec_stage.sv
  - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
